// ==== rtl/gb_pkg.sv ====
// handheld console i/o block
// shared memory map and types
`default_nettype none

package gb_pkg;

	// ------------------------------
	// bus widths
	localparam int ADDR_W  = 16;
	localparam int DATA_W  = 8;
	localparam int IRQ_N   = 5;    // vblank, lcd, timer, serial, joypad
	localparam int WRAM_AW = 15;   // 8 banks of 4k
	localparam int ZP_AW   = 7;    // ff80..fffe

	// ------------------------------
	// register map
	localparam logic [ADDR_W-1:0] ADDR_JOYP = 16'hff00;
	localparam logic [ADDR_W-1:0] ADDR_DIV  = 16'hff04;
	localparam logic [ADDR_W-1:0] ADDR_TIMA = 16'hff05;
	localparam logic [ADDR_W-1:0] ADDR_TMA  = 16'hff06;
	localparam logic [ADDR_W-1:0] ADDR_TAC  = 16'hff07;
	localparam logic [ADDR_W-1:0] ADDR_IF   = 16'hff0f;
	localparam logic [ADDR_W-1:0] ADDR_IE   = 16'hffff;
	localparam logic [ADDR_W-1:0] ADDR_SVBK = 16'hff70;  // gbc only
	localparam logic [ADDR_W-1:0] ZP_BASE   = 16'hff80;

	// ------------------------------
	// interrupts
	localparam logic [DATA_W-1:0] IRQ_VEC_BASE = 8'h40;  // source n at base + 8n
	localparam logic [DATA_W-1:0] IRQ_VEC_NONE = 8'h55;

	localparam int IRQ_VBLANK = 0;
	localparam int IRQ_LCD    = 1;
	localparam int IRQ_TIMER  = 2;
	localparam int IRQ_SERIAL = 3;
	localparam int IRQ_JOYPAD = 4;

	typedef enum logic {IRQ_IDLE, IRQ_ACK} irq_state_t;

	// read source picked by the decoder
	typedef enum logic [2:0] {
		SEL_NONE, SEL_JOYP, SEL_TIMER, SEL_IF, SEL_IE, SEL_WRAM, SEL_ZP, SEL_SVBK
	} reg_sel_t;

	// div bit watched by tima, indexed by tac[1:0]
	localparam int unsigned TAC_TAP [4] = '{9, 3, 5, 7};

endpackage

`default_nettype wire

// ==== rtl/bus_decode.sv ====
// address decoder and read mux
`timescale 1ns/1ps
`default_nettype none

module bus_decode import gb_pkg::*; (
	input  wire              clk_cpu,
	input  wire              reset,
	input  wire              is_gbc,
	input  wire [ADDR_W-1:0] cpu_addr,
	input  wire              cpu_wr,
	input  wire              cpu_rd,
	input  wire [DATA_W-1:0] joyp_data,
	input  wire [DATA_W-1:0] timer_data,
	input  wire [DATA_W-1:0] if_data,
	input  wire [DATA_W-1:0] ie_data,
	input  wire [DATA_W-1:0] wram_data,
	input  wire [DATA_W-1:0] zp_data,
	input  wire [DATA_W-1:0] svbk_data,
	output logic             joyp_we,
	output logic             timer_we,
	output logic [1:0]       timer_idx,
	output logic             if_we,
	output logic             ie_we,
	output logic             svbk_we,
	output logic             wram_we,
	output logic             zp_we,
	output logic [DATA_W-1:0] cpu_rdata
);

	reg_sel_t sel, sel_q;
	logic rd_q;                          // read data valid this cycle
	logic [DATA_W-1:0] reg_val, reg_q, rd_mux, hold_q;

	// ------------------------------
	// one compare per region, order matters
	always_comb begin
		sel = SEL_NONE;  // unmapped
		if (cpu_addr == ADDR_JOYP)
			sel = SEL_JOYP;
		else if (cpu_addr[ADDR_W-1:2] == ADDR_DIV[ADDR_W-1:2])
			sel = SEL_TIMER;             // ff04..ff07
		else if (cpu_addr == ADDR_IF)
			sel = SEL_IF;
		else if (cpu_addr == ADDR_IE)
			sel = SEL_IE;                // before zp, ffff sits in its window
		else if (cpu_addr == ADDR_SVBK && is_gbc)
			sel = SEL_SVBK;
		else if (cpu_addr[ADDR_W-1:ZP_AW] == ZP_BASE[ADDR_W-1:ZP_AW])
			sel = SEL_ZP;
		else if (cpu_addr[15:14] == 2'b11 && cpu_addr[15:9] != 7'h7f)
			sel = SEL_WRAM;              // c000..fdff incl. echo
	end

	assign timer_idx = cpu_addr[1:0];
	assign joyp_we   = cpu_wr && (sel == SEL_JOYP);
	assign timer_we  = cpu_wr && (sel == SEL_TIMER);
	assign if_we     = cpu_wr && (sel == SEL_IF);
	assign ie_we     = cpu_wr && (sel == SEL_IE);
	assign svbk_we   = cpu_wr && (sel == SEL_SVBK);  // gbc gate already in sel
	assign wram_we   = cpu_wr && (sel == SEL_WRAM);
	assign zp_we     = cpu_wr && (sel == SEL_ZP);

	// register sources sampled at the strobe
	always_comb begin
		case (sel)
			SEL_JOYP:  reg_val = joyp_data;
			SEL_TIMER: reg_val = timer_data;
			SEL_IF:    reg_val = if_data;
			SEL_IE:    reg_val = ie_data;
			SEL_SVBK:  reg_val = svbk_data;
			default:   reg_val = 8'hff;
		endcase
	end

	// rams answer one cycle late, same as reg_q
	always_comb begin
		case (sel_q)
			SEL_WRAM: rd_mux = wram_data;
			SEL_ZP:   rd_mux = zp_data;
			default:  rd_mux = reg_q;
		endcase
	end

	always_ff @(posedge clk_cpu) begin
		if (cpu_rd)
			reg_q <= reg_val;
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sel_q  <= SEL_NONE;
			rd_q   <= 1'b0;
			hold_q <= 8'hff;
		end else begin
			rd_q <= cpu_rd;
			if (cpu_rd)
				sel_q <= sel;
			if (rd_q)
				hold_q <= rd_mux;  // keep value once ram output moves on
		end
	end

	assign cpu_rdata = rd_q ? rd_mux : hold_q;

endmodule

`default_nettype wire

// ==== rtl/irq_ctrl.sv ====
// interrupt flag, enable and acknowledge
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl import gb_pkg::*; (
	input  wire              clk_cpu,
	input  wire              reset,
	input  wire [DATA_W-1:0] cpu_wdata,
	input  wire              if_we,
	input  wire              ie_we,
	input  wire              timer_irq,
	input  wire              key_irq,
	input  wire              cpu_ack,
	output logic [DATA_W-1:0] if_data,
	output logic [DATA_W-1:0] ie_data,
	output logic              irq_n,
	output logic [DATA_W-1:0] irq_vec
);

	irq_state_t state;
	logic [IRQ_N-1:0] if_r, ie_r, pend, events, pri_src, src_q;
	logic [DATA_W-1:0] pri_vec, vec_q;
	logic ack_done;

	assign pend    = if_r & ie_r;
	assign irq_n   = ~|pend;  // straight from the registers
	assign if_data = {{(DATA_W-IRQ_N){1'b1}}, if_r};
	assign ie_data = {{(DATA_W-IRQ_N){1'b0}}, ie_r};
	assign irq_vec = (state == IRQ_ACK) ? vec_q : pri_vec;
	assign ack_done = (state == IRQ_ACK) && !cpu_ack;  // ack just dropped

	// event sources
	always_comb begin
		events[IRQ_VBLANK] = 1'b0;  // no video here, cpu writes only
		events[IRQ_LCD]    = 1'b0;
		events[IRQ_TIMER]  = timer_irq;
		events[IRQ_SERIAL] = 1'b0;  // no link port either
		events[IRQ_JOYPAD] = key_irq;
	end

	// lowest pending bit wins, scan from the top
	always_comb begin
		pri_vec = IRQ_VEC_NONE;
		pri_src = '0;
		for (int i = IRQ_N - 1; i >= IRQ_VBLANK; i--) begin
			if (pend[i]) begin
				pri_vec = IRQ_VEC_BASE + DATA_W'(i * 8);
				pri_src = IRQ_N'(1) << i;
			end
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			state <= IRQ_IDLE;
			if_r  <= '0;
			ie_r  <= '0;
			src_q <= '0;
			vec_q <= IRQ_VEC_NONE;
		end else begin
			case (state)
				IRQ_IDLE: if (cpu_ack) begin
					state <= IRQ_ACK;
					vec_q <= pri_vec;  // frozen for the whole ack
					src_q <= pri_src;
				end
				IRQ_ACK: if (!cpu_ack)
					state <= IRQ_IDLE;
				default: state <= IRQ_IDLE;
			endcase

			// cpu write beats events and ack clear
			if (if_we)
				if_r <= cpu_wdata[IRQ_N-1:0];
			else if (ack_done)
				if_r <= (if_r & ~src_q) | events;
			else
				if_r <= if_r | events;

			if (ie_we)
				ie_r <= cpu_wdata[IRQ_N-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/timer.sv ====
// div / tima timer
`timescale 1ns/1ps
`default_nettype none

module timer import gb_pkg::*; (
	input  wire              clk_cpu,
	input  wire              reset,
	input  wire [DATA_W-1:0] cpu_wdata,
	input  wire              timer_we,
	input  wire [1:0]        timer_idx,
	output logic [DATA_W-1:0] timer_data,
	output logic              timer_irq
);

	logic [2*DATA_W-1:0] div_q;    // free running, top byte visible
	logic [DATA_W-1:0] tima_q, tma_q;
	logic [2:0] tac_q;             // enable, rate
	logic tap, tap_q, tick;

	// selected div bit, forced low when stopped
	assign tap  = div_q[TAC_TAP[tac_q[1:0]]] & tac_q[2];
	assign tick = tap_q & ~tap;  // falling edge
	assign timer_irq = tick && (tima_q == '1);  // wrap this cycle

	always_comb begin
		case (timer_idx)
			ADDR_DIV[1:0]:  timer_data = div_q[2*DATA_W-1:DATA_W];
			ADDR_TIMA[1:0]: timer_data = tima_q;
			ADDR_TMA[1:0]:  timer_data = tma_q;
			default:        timer_data = {5'b11111, tac_q};
		endcase
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			div_q  <= '0;
			tima_q <= '0;
			tma_q  <= '0;
			tac_q  <= '0;
			tap_q  <= 1'b0;
		end else begin
			tap_q <= tap;

			// any div write clears the full counter
			if (timer_we && timer_idx == ADDR_DIV[1:0])
				div_q <= '0;
			else
				div_q <= div_q + 1'b1;

			if (timer_we && timer_idx == ADDR_TIMA[1:0])
				tima_q <= cpu_wdata;
			else if (timer_irq)
				tima_q <= tma_q;          // reload on overflow
			else if (tick)
				tima_q <= tima_q + 1'b1;

			if (timer_we && timer_idx == ADDR_TMA[1:0])
				tma_q <= cpu_wdata;
			if (timer_we && timer_idx == ADDR_TAC[1:0])
				tac_q <= cpu_wdata[2:0];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/joypad.sv ====
// joypad select and key interrupt
`timescale 1ns/1ps
`default_nettype none

module joypad import gb_pkg::*; (
	input  wire              clk_cpu,
	input  wire              reset,
	input  wire [DATA_W-1:0] cpu_wdata,
	input  wire              joyp_we,
	input  wire [7:0]        joystick,   // active high, pressed = 1
	output logic [DATA_W-1:0] joyp_data,
	output logic              key_irq
);

	logic [1:0] p54;                     // select, 0 = group on
	logic [3:0] dir_n, btn_n;            // low active per group
	logic [7:0] key_d1, key_d2;

	// key order: dpad group on p54[0], buttons on p54[1]
	assign dir_n = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{p54[0]}};
	assign btn_n = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{p54[1]}};

	assign joyp_data = {2'b11, p54, dir_n & btn_n};
	assign key_irq   = |(~key_d1 & key_d2);  // any selected line fell

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			p54    <= 2'b00;
			key_d1 <= '1;  // idle lines are high
			key_d2 <= '1;
		end else begin
			if (joyp_we)
				p54 <= cpu_wdata[5:4];
			key_d1 <= {dir_n, btn_n};
			key_d2 <= key_d1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/work_ram.sv ====
// zero page and banked work ram
`timescale 1ns/1ps
`default_nettype none

module work_ram import gb_pkg::*; (
	input  wire              clk_cpu,
	input  wire              reset,
	input  wire              is_gbc,
	input  wire [ADDR_W-1:0] cpu_addr,
	input  wire [DATA_W-1:0] cpu_wdata,
	input  wire              svbk_we,
	input  wire              wram_we,
	input  wire              zp_we,
	output logic [DATA_W-1:0] wram_data,
	output logic [DATA_W-1:0] zp_data,
	output logic [DATA_W-1:0] svbk_data
);

	logic [DATA_W-1:0] wram [2**WRAM_AW];
	logic [DATA_W-1:0] zp   [2**ZP_AW];  // top entry never decoded
	logic [2:0] bank_q;                  // 1..7
	logic [2:0] bank;
	logic [WRAM_AW-1:0] wram_addr;

	assign bank = is_gbc ? bank_q : 3'd1;  // dmg sees a fixed bank 1
	assign svbk_data = {5'b11111, bank_q};

	// d000 half banked, c000 half always bank 0, echo folds in via addr[12:0]
	assign wram_addr = cpu_addr[12] ? {bank, cpu_addr[11:0]} : {3'd0, cpu_addr[11:0]};

	always_ff @(posedge clk_cpu) begin
		if (wram_we)
			wram[wram_addr] <= cpu_wdata;
		wram_data <= wram[wram_addr];
	end

	always_ff @(posedge clk_cpu) begin
		if (zp_we)
			zp[cpu_addr[ZP_AW-1:0]] <= cpu_wdata;
		zp_data <= zp[cpu_addr[ZP_AW-1:0]];
	end

	// svbk, 0 maps to 1
	always_ff @(posedge clk_cpu) begin
		if (reset)
			bank_q <= 3'd1;
		else if (svbk_we)
			bank_q <= (cpu_wdata[2:0] == 3'd0) ? 3'd1 : cpu_wdata[2:0];
	end

endmodule

`default_nettype wire

// ==== rtl/gb_io.sv ====
// console i/o and memory-mapped register block
`timescale 1ns/1ps
`default_nettype none

module gb_io import gb_pkg::*; (
	input  wire              clk_cpu,
	input  wire              reset,
	input  wire              is_gbc,
	input  wire [ADDR_W-1:0] cpu_addr,
	input  wire [DATA_W-1:0] cpu_wdata,
	input  wire              cpu_wr,      // one-cycle strobes
	input  wire              cpu_rd,
	input  wire              cpu_ack,     // held for the whole ack
	input  wire [7:0]        joystick,
	output logic [DATA_W-1:0] cpu_rdata,
	output logic              irq_n,
	output logic [DATA_W-1:0] irq_vec
);

	// write enables from the decoder
	logic joyp_we, timer_we, if_we, ie_we, svbk_we, wram_we, zp_we;
	logic [1:0] timer_idx;

	// read values back into the mux
	logic [DATA_W-1:0] joyp_data, timer_data, if_data, ie_data;
	logic [DATA_W-1:0] wram_data, zp_data, svbk_data;

	logic timer_irq, key_irq;  // event pulses

	bus_decode u_decode (
		.clk_cpu(clk_cpu), .reset(reset), .is_gbc(is_gbc),
		.cpu_addr(cpu_addr), .cpu_wr(cpu_wr), .cpu_rd(cpu_rd),
		.joyp_data(joyp_data), .timer_data(timer_data), .if_data(if_data),
		.ie_data(ie_data), .wram_data(wram_data), .zp_data(zp_data),
		.svbk_data(svbk_data),
		.joyp_we(joyp_we), .timer_we(timer_we), .timer_idx(timer_idx),
		.if_we(if_we), .ie_we(ie_we), .svbk_we(svbk_we),
		.wram_we(wram_we), .zp_we(zp_we), .cpu_rdata(cpu_rdata)
	);

	irq_ctrl u_irq (
		.clk_cpu(clk_cpu), .reset(reset), .cpu_wdata(cpu_wdata),
		.if_we(if_we), .ie_we(ie_we), .timer_irq(timer_irq), .key_irq(key_irq),
		.cpu_ack(cpu_ack), .if_data(if_data), .ie_data(ie_data),
		.irq_n(irq_n), .irq_vec(irq_vec)
	);

	timer u_timer (
		.clk_cpu(clk_cpu), .reset(reset), .cpu_wdata(cpu_wdata),
		.timer_we(timer_we), .timer_idx(timer_idx),
		.timer_data(timer_data), .timer_irq(timer_irq)
	);

	joypad u_joypad (
		.clk_cpu(clk_cpu), .reset(reset), .cpu_wdata(cpu_wdata),
		.joyp_we(joyp_we), .joystick(joystick),
		.joyp_data(joyp_data), .key_irq(key_irq)
	);

	work_ram u_ram (
		.clk_cpu(clk_cpu), .reset(reset), .is_gbc(is_gbc),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.svbk_we(svbk_we), .wram_we(wram_we), .zp_we(zp_we),
		.wram_data(wram_data), .zp_data(zp_data), .svbk_data(svbk_data)
	);

endmodule

`default_nettype wire

// ==== verification/clock_gen.sv ====
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic clk_cpu,
	output logic reset
);

	initial begin
		clk_cpu = 1'b0;
		forever #5 clk_cpu = ~clk_cpu;  // 10 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk_cpu);
		reset <= 1'b0;  // drops just after the third rising edge
	end

endmodule

`default_nettype wire

// ==== verification/gb_io_tb.sv ====
// gb_io register block testbench
`timescale 1ns/1ps
`default_nettype none

module gb_io_tb import gb_pkg::*; ();

	logic clk_cpu, reset;
	logic is_gbc, cpu_wr, cpu_rd, cpu_ack, irq_n;
	logic [ADDR_W-1:0] cpu_addr;
	logic [DATA_W-1:0] cpu_wdata, cpu_rdata, irq_vec;
	logic [7:0] joystick;

	// shadow copies for the reference model
	logic [DATA_W-1:0] wram_sh [2**WRAM_AW];
	logic [DATA_W-1:0] zp_sh [2**ZP_AW];
	logic [IRQ_N-1:0] if_sh, ie_sh;
	logic [2:0] bank_sh, tac_sh;
	logic [1:0] sel_sh;                 // joypad select
	logic [DATA_W-1:0] tma_sh;

	logic [31:0] lfsr;
	logic [DATA_W-1:0] exp_q [$];      // pending read compares
	logic [DATA_W-1:0] got_q [$];
	logic [ADDR_W-1:0] addr_q [$];
	time time_q [$];
	int err_count, test_base, tests_run, tests_failed;

	clock_gen u_clk (.clk_cpu(clk_cpu), .reset(reset));

	gb_io DUT (
		.clk_cpu(clk_cpu), .reset(reset), .is_gbc(is_gbc),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_wr(cpu_wr),
		.cpu_rd(cpu_rd), .cpu_ack(cpu_ack), .joystick(joystick),
		.cpu_rdata(cpu_rdata), .irq_n(irq_n), .irq_vec(irq_vec)
	);

	// ------------------------------
	// stimulus source
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);  // one step per bit
		end
		return r;
	endfunction

	// ------------------------------
	// reference model
	function automatic int wram_index(input logic [ADDR_W-1:0] a);
		logic [2:0] b;
		b = is_gbc ? bank_sh : 3'd1;
		if (!a[12])
			b = 3'd0;                    // lower 4k always bank 0
		return int'({b, a[11:0]});       // echo folds in through a[12:0]
	endfunction

	function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] a);
		logic [3:0] keys;
		keys = 4'hf;
		if (!sel_sh[0])
			keys = keys & ~{joystick[2], joystick[3], joystick[1], joystick[0]};
		if (!sel_sh[1])
			keys = keys & ~joystick[7:4];  // buttons
		if (a == ADDR_JOYP) return {2'b11, sel_sh, keys};
		if (a == ADDR_TMA) return tma_sh;
		if (a == ADDR_TAC) return {5'b11111, tac_sh};
		if (a == ADDR_IF) return {3'b111, if_sh};
		if (a == ADDR_IE) return {3'b000, ie_sh};
		if (a == ADDR_SVBK) return is_gbc ? {5'b11111, bank_sh} : 8'hff;
		if (a >= ZP_BASE) return zp_sh[a[ZP_AW-1:0]];
		if (a >= 16'hc000 && a < 16'hfe00) return wram_sh[wram_index(a)];
		return 8'hff;                    // unmapped
	endfunction

	function automatic void shadow_write(input logic [ADDR_W-1:0] a, input logic [7:0] d);
		if (a == ADDR_JOYP) sel_sh = d[5:4];
		else if (a == ADDR_TMA) tma_sh = d;
		else if (a == ADDR_TAC) tac_sh = d[2:0];
		else if (a == ADDR_IF) if_sh = d[IRQ_N-1:0];
		else if (a == ADDR_IE) ie_sh = d[IRQ_N-1:0];
		else if (a == ADDR_SVBK) begin
			if (is_gbc)
				bank_sh = (d[2:0] == 3'd0) ? 3'd1 : d[2:0];  // 0 means 1
		end
		else if (a >= ZP_BASE) zp_sh[a[ZP_AW-1:0]] = d;
		else if (a >= 16'hc000 && a < 16'hfe00) wram_sh[wram_index(a)] = d;
	endfunction

	function automatic int lowest_bit(input logic [IRQ_N-1:0] p);
		for (int i = 0; i < IRQ_N; i++)
			if (p[i]) return i;
		return -1;
	endfunction

	function automatic logic [DATA_W-1:0] expected_vector(input logic [IRQ_N-1:0] p);
		int n;
		n = lowest_bit(p);
		return (n < 0) ? IRQ_VEC_NONE : IRQ_VEC_BASE + 8'(8 * n);
	endfunction

	// ------------------------------
	// bus tasks, all start and end on a falling edge
	task automatic cycles(input int n);
		repeat (n) @(negedge clk_cpu);
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		cpu_addr = a;
		cpu_wdata = d;
		cpu_wr = 1'b1;
		@(negedge clk_cpu);
		cpu_wr = 1'b0;
		shadow_write(a, d);
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
		cpu_addr = a;
		cpu_rd = 1'b1;
		@(negedge clk_cpu);
		cpu_rd = 1'b0;
		d = cpu_rdata;                   // settled since the rising edge
	endtask

	task automatic check_read(input logic [ADDR_W-1:0] a);
		logic [DATA_W-1:0] v;
		bus_read(a, v);
		exp_q.push_back(model_read(a));
		got_q.push_back(v);
		addr_q.push_back(a);
		time_q.push_back($time);
	endtask

	task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %0d ns: %s got %02h, expected %02h", $time, what, got, exp);
			err_count++;
		end
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		@(negedge clk_cpu);
		while (reset && n < 20) begin
			@(negedge clk_cpu);
			n++;
		end
		if (reset) begin
			$display("reset was never released");
			err_count++;
		end
	endtask

	// poll IF through the bus, one read per cycle
	task automatic wait_if_bit(input int b, input int limit, input string what);
		logic [DATA_W-1:0] v;
		int n;
		n = 0;
		v = 8'h00;
		while (!v[b] && n < limit) begin
			bus_read(ADDR_IF, v);
			n++;
		end
		if (!v[b]) begin
			$display("timeout: %s, IF bit %0d not set within %0d cycles", what, b, limit);
			err_count++;
		end
	endtask

	// visible DIV byte must be off zero so a clear shows
	task automatic wait_div_running(input int limit);
		logic [DATA_W-1:0] v;
		int n;
		n = 0;
		v = 8'h00;
		while (v == 8'h00 && n < limit) begin
			bus_read(ADDR_DIV, v);
			n++;
		end
		if (v == 8'h00) begin
			$display("timeout: DIV still read zero after %0d cycles", limit);
			err_count++;
		end
	endtask

	task automatic drain_checks();
		int n;
		n = 0;
		while (exp_q.size() > 0 && n < 10) begin
			@(negedge clk_cpu);
			n++;
		end
		if (exp_q.size() > 0) begin
			$display("read compares were still pending after 10 cycles");
			err_count++;
		end
	endtask

	task automatic test_done(input string name);
		int errs;
		drain_checks();
		errs = err_count - test_base;
		tests_run++;
		if (errs == 0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d wrong", tests_run, name, errs);
		end
		test_base = err_count;
	endtask

	// ------------------------------
	// compare process for bus reads
	initial begin : compare_reads
		logic [DATA_W-1:0] e, g;
		logic [ADDR_W-1:0] a;
		time t;
		forever begin
			@(posedge clk_cpu);
			while (exp_q.size() > 0) begin
				e = exp_q.pop_front();
				g = got_q.pop_front();
				a = addr_q.pop_front();
				t = time_q.pop_front();
				assert (g === e) else begin
					$display("[ERROR] %0d ns: read %04h got %02h, expected %02h", t, a, g, e);
					err_count++;
				end
			end
		end
	end

	initial begin : stimulus
		logic [ADDR_W-1:0] wr_addrs [$];
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] v;
		logic [2:0] b;
		int src;
		is_gbc = 1'b1;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_wr = 1'b0;
		cpu_rd = 1'b0;
		cpu_ack = 1'b0;
		joystick = 8'h00;                // nothing pressed
		lfsr = 32'hcb17_2624;
		err_count = 0;
		test_base = 0;
		tests_run = 0;
		tests_failed = 0;
		if_sh = '0;
		ie_sh = '0;
		bank_sh = 3'd1;
		sel_sh = 2'b00;
		tma_sh = '0;
		tac_sh = '0;
		wait_reset();

		// memory round trip, zp / bank 0 / echo
		check_value("rdata after reset", cpu_rdata, 8'hff);
		check_value("irq_n after reset", {7'd0, irq_n}, 8'd1);
		for (int i = 0; i < 64; i++) begin
			case (rand_bits(2) % 3)
				0: a = ZP_BASE + 16'(rand_bits(7) % 32'd127);  // skips ffff
				1: a = 16'hc000 | 16'(rand_bits(12));
				default: a = 16'he000 + 16'(rand_bits(13) % 32'h1e00);
			endcase
			wr_addrs.push_back(a);
			bus_write(a, 8'(rand_bits(8)));
		end
		foreach (wr_addrs[i]) begin
			check_read(wr_addrs[i]);
			if (wr_addrs[i] >= 16'hc000 && wr_addrs[i] < 16'hde00)
				check_read(wr_addrs[i] + 16'h2000);  // echo alias
			else if (wr_addrs[i] >= 16'he000 && wr_addrs[i] < 16'hfe00)
				check_read(wr_addrs[i] - 16'h2000);
		end
		check_read(16'hff01);
		check_read(16'hfe00);            // oam, not decoded here
		check_read(16'hff7f);
		check_read(16'h1234);
		test_done("memory round trip");

		// work ram banking
		a = 16'hd000 | {4'h0, 12'(rand_bits(12))};
		for (int k = 0; k < 3; k++) begin
			b = 3'((2 << k) - 1);        // banks 1, 3, 7
			bus_write(ADDR_SVBK, {5'd0, b});
			bus_write(a, {5'(rand_bits(5)), b});  // low bits keep data distinct
		end
		for (int k = 0; k < 3; k++) begin
			b = 3'((2 << k) - 1);
			bus_write(ADDR_SVBK, {5'd0, b});
			check_read(ADDR_SVBK);
			check_read(a);
		end
		bus_write(ADDR_SVBK, 8'h00);
		check_read(ADDR_SVBK);
		check_read(a);
		bus_write(ADDR_SVBK, 8'h03);     // dmg must still see bank 1
		is_gbc = 1'b0;                   // dmg mode, bank fixed
		bus_write(ADDR_SVBK, 8'h05);
		check_read(ADDR_SVBK);
		check_read(a);
		is_gbc = 1'b1;
		check_read(ADDR_SVBK);
		test_done("work ram banking");

		// timer overflow and div clear
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_TMA, 8'ha0);
		bus_write(ADDR_TIMA, 8'hfe);
		bus_write(ADDR_TAC, 8'h05);      // on, div bit 3
		check_read(ADDR_TMA);
		check_read(ADDR_TAC);
		wait_if_bit(IRQ_TIMER, 200, "timer overflow");
		bus_read(ADDR_TIMA, v);
		assert (v === tma_sh || v === tma_sh + 8'd1) else begin
			$display("[ERROR] %0d ns: TIMA after reload got %02h, expected %02h or %02h",
				$time, v, tma_sh, tma_sh + 8'd1);
			err_count++;
		end
		wait_div_running(300);
		bus_write(ADDR_DIV, 8'(rand_bits(8)));
		bus_read(ADDR_DIV, v);
		check_value("DIV after write", v, 8'h00);
		bus_write(ADDR_TAC, 8'h00);
		bus_write(ADDR_IF, 8'h00);       // resync the IF copy
		test_done("timer");

		// joypad matrix and key interrupt
		for (int i = 0; i < 16; i++) begin
			bus_write(ADDR_JOYP, {2'b00, 2'(rand_bits(2)), 4'h0});
			joystick = 8'(rand_bits(8));
			check_read(ADDR_JOYP);
		end
		joystick = 8'h00;
		bus_write(ADDR_JOYP, 8'h20);     // dpad group only
		cycles(4);
		bus_write(ADDR_IF, 8'h00);
		joystick = 8'(32'd1 << rand_bits(2));
		wait_if_bit(IRQ_JOYPAD, 20, "key press");
		check_read(ADDR_JOYP);
		joystick = 8'h00;
		cycles(4);
		bus_write(ADDR_IF, 8'h00);
		test_done("joypad");

		// priority and acknowledge
		bus_write(ADDR_IF, 8'h1f);
		bus_write(ADDR_IE, 8'h1a);
		check_value("irq_n with pending", {7'd0, irq_n}, 8'd0);
		check_read(ADDR_IE);
		for (int k = 0; k < 3; k++) begin
			src = lowest_bit(if_sh & ie_sh);
			cpu_ack = 1'b1;
			cycles(2);
			check_value("irq_vec during ack", irq_vec, expected_vector(if_sh & ie_sh));
			cpu_ack = 1'b0;
			cycles(1);                   // flag clears on the edge after ack drops
			if (src >= 0)
				if_sh[src] = 1'b0;
			check_read(ADDR_IF);
		end
		check_value("irq_n with none pending", {7'd0, irq_n}, 8'd1);
		check_value("irq_vec idle", irq_vec, IRQ_VEC_NONE);
		test_done("interrupt acknowledge");

		$display("%0d tests run, %0d failed, %0d checks wrong",
			tests_run, tests_failed, err_count);
		if (err_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== gb_io.f ====
rtl/gb_pkg.sv
rtl/bus_decode.sv
rtl/irq_ctrl.sv
rtl/timer.sv
rtl/joypad.sv
rtl/work_ram.sv
rtl/gb_io.sv
verification/clock_gen.sv
verification/gb_io_tb.sv

// ==== Makefile ====
# verilator flow for the gb_io testbench

TOP = gb_io_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f gb_io.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
